// ==== common/vcpu_pkg.sv ====
// fixed 16 x 32-bit register set; widths are not meant to be changed
`default_nettype none

package vcpu_pkg;

    localparam int unsigned XLEN  = 32;
    localparam int unsigned NREGS = 16;

    // register shifts above 32 collapse onto this amount
    localparam int unsigned SHIFT_SAT = 33;

    typedef logic [XLEN-1:0]          word_t;
    typedef logic [$clog2(NREGS)-1:0] reg_idx_t;

    localparam reg_idx_t REG_SP = 4'd13;
    localparam reg_idx_t REG_LR = 4'd14;
    localparam reg_idx_t REG_PC = 4'd15;

    // sub, cmp and mvn run on OP_ADD with inverted operands
    typedef enum logic [3:0] {
        OP_LSL,
        OP_LSR,
        OP_ASR,
        OP_ROR,
        OP_ADD,
        OP_AND,
        OP_EOR,
        OP_ORR,
        OP_MUL,
        OP_NONE
    } alu_op_e;

    typedef struct packed {
        word_t value;
        logic  carry;
        logic  ovf;
    } unit_res_t;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

endpackage

`default_nettype wire

// ==== common/exec_if.sv ====
// one decoded operation per valid/ready transfer; payload is only meaningful with valid
`timescale 1ns/1ps
`default_nettype none

interface exec_if;
    import vcpu_pkg::*;

    logic       valid;
    logic       ready;
    alu_op_e    op;
    word_t      opn_n;
    word_t      opn_m;
    logic       carry_in;
    logic [5:0] shift_amt;
    reg_idx_t   rd;
    logic       write_en;
    logic       set_flags;

    modport decoder (
        output valid, op, opn_n, opn_m, carry_in, shift_amt, rd, write_en, set_flags,
        input  ready
    );

    modport writeback (
        input  valid, op, opn_n, opn_m, carry_in, shift_amt, rd, write_en, set_flags,
        output ready
    );

    // execution units only look at the operands
    modport unit (
        input op, opn_n, opn_m, carry_in, shift_amt
    );

endinterface

`default_nettype wire

// ==== common/rf_read_if.sv ====
// read data is combinational and already bypassed from the write in flight
`timescale 1ns/1ps
`default_nettype none

interface rf_read_if;
    import vcpu_pkg::*;

    reg_idx_t raddr_n;
    reg_idx_t raddr_m;
    word_t    rdata_n;
    word_t    rdata_m;
    logic     carry_q;

    modport requester (
        output raddr_n, raddr_m,
        input  rdata_n, rdata_m, carry_q
    );

    modport provider (
        input  raddr_n, raddr_m,
        output rdata_n, rdata_m, carry_q
    );

endinterface

`default_nettype wire

// ==== decode/thumb_decoder.sv ====
// unsupported encodings are consumed silently; immediate shift amounts are taken as encoded
`timescale 1ns/1ps
`default_nettype none

module thumb_decoder (
    input  logic        sck,
    input  logic        rst_n_i,
    input  logic        cmd_valid_i,
    input  logic [15:0] cmd_i,
    output logic        cmd_ready_o,
    exec_if.decoder     ex,
    rf_read_if.requester rf
);
    import vcpu_pkg::*;

    typedef enum logic [3:0] {
        DP_AND, DP_EOR, DP_LSL, DP_LSR,
        DP_ASR, DP_ADC, DP_SBC, DP_ROR,
        DP_TST, DP_RSB, DP_CMP, DP_CMN,
        DP_ORR, DP_MUL, DP_BIC, DP_MVN
    } dp_op_e;

    logic       accept;
    logic       is_addsub;
    logic       is_sh_imm;
    logic       is_imm8;
    logic       is_dp;
    logic       is_hi;
    dp_op_e     dp_op;
    logic [7:0] rs;
    logic [5:0] sat_amt;
    logic [5:0] ror_amt;

    logic       d_ok;
    alu_op_e    d_op;
    word_t      d_n;
    word_t      d_m;
    logic       d_cin;
    logic [5:0] d_amt;
    reg_idx_t   d_rd;
    logic       d_we;
    logic       d_sf;

    assign cmd_ready_o = !ex.valid || ex.ready;
    assign accept      = cmd_valid_i && cmd_ready_o;

    assign is_addsub = cmd_i[15:11] == 5'b00011;
    assign is_sh_imm = cmd_i[15:13] == 3'b000 && !is_addsub;
    assign is_imm8   = cmd_i[15:13] == 3'b001;
    assign is_dp     = cmd_i[15:10] == 6'b010000;
    // mode 11 is bx/blx, not handled here
    assign is_hi     = cmd_i[15:10] == 6'b010001 && cmd_i[9:8] != 2'b11;
    assign dp_op     = dp_op_e'(cmd_i[9:6]);

    // register shift amount from rm[7:0]
    assign rs      = rf.rdata_m[7:0];
    assign sat_amt = (rs > 8'(XLEN)) ? 6'(SHIFT_SAT) : rs[5:0];
    // nonzero multiple of 32 rotates by nothing but still sets carry from bit 31
    assign ror_amt = (rs != 8'd0 && rs[4:0] == 5'd0) ? 6'd32 : {1'b0, rs[4:0]};

    always_comb begin
        rf.raddr_n = {1'b0, cmd_i[2:0]};
        rf.raddr_m = {1'b0, cmd_i[5:3]};
        if (is_addsub || is_sh_imm) begin
            rf.raddr_n = {1'b0, cmd_i[5:3]};
            rf.raddr_m = {1'b0, cmd_i[8:6]};
        end else if (is_imm8) begin
            rf.raddr_n = {1'b0, cmd_i[10:8]};
        end else if (is_hi) begin
            rf.raddr_n = {cmd_i[7], cmd_i[2:0]};
            rf.raddr_m = cmd_i[6:3];
        end
    end

    always_comb begin
        d_ok  = 1'b0;
        d_op  = OP_NONE;
        d_n   = rf.rdata_n;
        d_m   = rf.rdata_m;
        d_cin = rf.carry_q;
        d_amt = '0;
        d_rd  = {1'b0, cmd_i[2:0]};
        d_we  = 1'b1;
        d_sf  = 1'b1;
        if (is_addsub) begin
            d_ok  = 1'b1;
            d_op  = OP_ADD;
            d_m   = cmd_i[10] ? word_t'(cmd_i[8:6]) : rf.rdata_m;
            d_m   = cmd_i[9] ? ~d_m : d_m;
            d_cin = cmd_i[9];
        end else if (is_sh_imm) begin
            d_ok  = 1'b1;
            d_op  = (cmd_i[12:11] == 2'b00) ? OP_LSL : (cmd_i[11] ? OP_LSR : OP_ASR);
            d_amt = {1'b0, cmd_i[10:6]};
        end else if (is_imm8) begin
            d_ok  = 1'b1;
            d_op  = OP_ADD;
            d_rd  = {1'b0, cmd_i[10:8]};
            d_m   = word_t'(cmd_i[7:0]);
            d_cin = 1'b0;
            case (cmd_i[12:11])
                2'b00: d_n = '0;
                2'b01: begin
                    d_m   = ~d_m;
                    d_cin = 1'b1;
                    d_we  = 1'b0;
                end
                2'b10: d_n = rf.rdata_n;
                default: begin
                    d_m   = ~d_m;
                    d_cin = 1'b1;
                end
            endcase
        end else if (is_dp) begin
            d_ok = 1'b1;
            case (dp_op)
                DP_AND: d_op = OP_AND;
                DP_EOR: d_op = OP_EOR;
                DP_LSL: begin
                    d_op  = OP_LSL;
                    d_amt = sat_amt;
                end
                DP_LSR: begin
                    d_op  = OP_LSR;
                    d_amt = sat_amt;
                end
                DP_ASR: begin
                    d_op  = OP_ASR;
                    d_amt = sat_amt;
                end
                DP_ADC: d_op = OP_ADD;
                DP_SBC: begin
                    d_op = OP_ADD;
                    d_m  = ~rf.rdata_m;
                end
                DP_ROR: begin
                    d_op  = OP_ROR;
                    d_amt = ror_amt;
                end
                DP_TST: begin
                    d_op = OP_AND;
                    d_we = 1'b0;
                end
                // neg source sits in bits 5:3
                DP_RSB: begin
                    d_op  = OP_ADD;
                    d_n   = '0;
                    d_m   = ~rf.rdata_m;
                    d_cin = 1'b1;
                end
                DP_CMP: begin
                    d_op  = OP_ADD;
                    d_m   = ~rf.rdata_m;
                    d_cin = 1'b1;
                    d_we  = 1'b0;
                end
                DP_CMN: begin
                    d_op  = OP_ADD;
                    d_cin = 1'b0;
                    d_we  = 1'b0;
                end
                DP_ORR: d_op = OP_ORR;
                DP_MUL: d_op = OP_MUL;
                DP_BIC: begin
                    d_op = OP_AND;
                    d_m  = ~rf.rdata_m;
                end
                DP_MVN: begin
                    d_op  = OP_ADD;
                    d_n   = '0;
                    d_m   = ~rf.rdata_m;
                    d_cin = 1'b0;
                end
            endcase
        end else if (is_hi) begin
            d_ok  = 1'b1;
            d_op  = OP_ADD;
            d_rd  = {cmd_i[7], cmd_i[2:0]};
            d_cin = 1'b0;
            // writes to r15 leave the flags alone
            d_sf  = d_rd != REG_PC;
            if (cmd_i[9:8] == 2'b01) begin
                d_m   = ~rf.rdata_m;
                d_cin = 1'b1;
                d_we  = 1'b0;
            end else if (cmd_i[9:8] == 2'b10) begin
                d_n = '0;
            end
        end
    end

    always_ff @(posedge sck) begin
        if (!rst_n_i) begin
            ex.valid <= 1'b0;
        end else if (cmd_ready_o) begin
            ex.valid <= cmd_valid_i && d_ok;
        end
    end

    always_ff @(posedge sck) begin
        if (accept) begin
            ex.op        <= d_op;
            ex.opn_n     <= d_n;
            ex.opn_m     <= d_m;
            ex.carry_in  <= d_cin;
            ex.shift_amt <= d_amt;
            ex.rd        <= d_rd;
            ex.write_en  <= d_we;
            ex.set_flags <= d_sf;
        end
    end

    // a fresh exec entry must come from an accepted command
    a_valid_from_accept: assert property (@(posedge sck) disable iff (!rst_n_i)
        ex.valid && $past(!ex.valid || ex.ready) |-> $past(accept));

endmodule

`default_nettype wire

// ==== execute/shift_unit.sv ====
// shift_amt above 32 must already be saturated; ror uses the low five bits only
`timescale 1ns/1ps
`default_nettype none

module shift_unit (
    exec_if.unit                 ex,
    output vcpu_pkg::unit_res_t  res_o
);
    import vcpu_pkg::*;

    logic [XLEN:0]     lsl_ext;
    logic [XLEN:0]     lsr_ext;
    logic [XLEN:0]     asr_ext;
    logic [2*XLEN-1:0] ror_ext;

    // one guard bit catches the last bit shifted out
    assign lsl_ext = {1'b0, ex.opn_n} << ex.shift_amt;
    assign lsr_ext = {ex.opn_n, 1'b0} >> ex.shift_amt;
    assign asr_ext = $signed({ex.opn_n, 1'b0}) >>> ex.shift_amt;
    assign ror_ext = {ex.opn_n, ex.opn_n} >> ex.shift_amt[4:0];

    always_comb begin
        res_o.ovf = 1'b0;
        case (ex.op)
            OP_LSL: begin
                res_o.value = lsl_ext[XLEN-1:0];
                res_o.carry = lsl_ext[XLEN];
            end
            OP_LSR: begin
                res_o.value = lsr_ext[XLEN:1];
                res_o.carry = lsr_ext[0];
            end
            OP_ASR: begin
                res_o.value = asr_ext[XLEN:1];
                res_o.carry = asr_ext[0];
            end
            default: begin
                res_o.value = ror_ext[XLEN-1:0];
                res_o.carry = ror_ext[XLEN-1];
            end
        endcase
        // zero amount keeps the old carry
        if (ex.shift_amt == 6'd0) begin
            res_o.carry = ex.carry_in;
        end
    end

endmodule

`default_nettype wire

// ==== execute/adder_unit.sv ====
// subtraction arrives as inverted m with carry-in set
`timescale 1ns/1ps
`default_nettype none

module adder_unit (
    exec_if.unit                 ex,
    output vcpu_pkg::unit_res_t  res_o
);
    import vcpu_pkg::*;

    logic [XLEN:0] sum;
    logic          same_sign;

    assign sum = {1'b0, ex.opn_n} + {1'b0, ex.opn_m} + {{XLEN{1'b0}}, ex.carry_in};
    assign same_sign = ex.opn_n[XLEN-1] == ex.opn_m[XLEN-1];

    always_comb begin
        res_o.value = sum[XLEN-1:0];
        res_o.carry = sum[XLEN];
        // signed overflow
        res_o.ovf   = same_sign && (sum[XLEN-1] != ex.opn_n[XLEN-1]);
    end

endmodule

`default_nettype wire

// ==== execute/logic_mul_unit.sv ====
// bic comes in as and with inverted m; multiply keeps only the low word
`timescale 1ns/1ps
`default_nettype none

module logic_mul_unit (
    exec_if.unit                 ex,
    output vcpu_pkg::unit_res_t  res_o
);
    import vcpu_pkg::*;

    logic [2*XLEN-1:0] product;

    assign product = ex.opn_n * ex.opn_m;

    always_comb begin
        // carry passes through untouched
        res_o.carry = ex.carry_in;
        res_o.ovf   = 1'b0;
        case (ex.op)
            OP_EOR:  res_o.value = ex.opn_n ^ ex.opn_m;
            OP_ORR:  res_o.value = ex.opn_n | ex.opn_m;
            OP_MUL:  res_o.value = product[XLEN-1:0];
            default: res_o.value = ex.opn_n & ex.opn_m;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
// every exec op yields one result, compares included; v changes only on adder ops
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                sck,
    input  logic                rst_n_i,
    exec_if.writeback           ex,
    rf_read_if.provider         rf,
    input  vcpu_pkg::unit_res_t shift_res_i,
    input  vcpu_pkg::unit_res_t add_res_i,
    input  vcpu_pkg::unit_res_t logic_res_i,
    output logic                res_valid_o,
    output vcpu_pkg::word_t     res_value_o,
    output vcpu_pkg::reg_idx_t  res_rd_o,
    input  logic                res_ready_i,
    output vcpu_pkg::flags_t    flags_o
);
    import vcpu_pkg::*;

    word_t     regs [NREGS];
    flags_t    flags_q;
    unit_res_t sel;
    logic      fire;
    logic      wr_reg;
    logic      wr_flags;

    assign ex.ready = !res_valid_o || res_ready_i;
    assign fire     = ex.valid && ex.ready;
    assign wr_reg   = fire && ex.write_en;
    assign wr_flags = fire && ex.set_flags;
    assign flags_o  = flags_q;

    always_comb begin
        case (ex.op)
            OP_LSL, OP_LSR, OP_ASR, OP_ROR: sel = shift_res_i;
            OP_ADD:                         sel = add_res_i;
            default:                        sel = logic_res_i;
        endcase
    end

    // forward the value being written this edge
    assign rf.rdata_n = (wr_reg && ex.rd == rf.raddr_n) ? sel.value : regs[rf.raddr_n];
    assign rf.rdata_m = (wr_reg && ex.rd == rf.raddr_m) ? sel.value : regs[rf.raddr_m];
    assign rf.carry_q = wr_flags ? sel.carry : flags_q.c;

    always_ff @(posedge sck) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
            flags_q <= '0;
        end else begin
            if (wr_reg) begin
                regs[ex.rd] <= sel.value;
            end
            if (wr_flags) begin
                flags_q.n <= sel.value[XLEN-1];
                flags_q.z <= sel.value == '0;
                flags_q.c <= sel.carry;
                if (ex.op == OP_ADD) begin
                    flags_q.v <= sel.ovf;
                end
            end
        end
    end

    always_ff @(posedge sck) begin
        if (!rst_n_i) begin
            res_valid_o <= 1'b0;
        end else if (fire) begin
            res_valid_o <= 1'b1;
        end else if (res_ready_i) begin
            res_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge sck) begin
        if (fire) begin
            res_value_o <= sel.value;
            res_rd_o    <= ex.rd;
        end
    end

    // stalled result must hold until taken
    a_res_hold: assert property (@(posedge sck) disable iff (!rst_n_i)
        res_valid_o && !res_ready_i |=> res_valid_o && $stable(res_value_o));

endmodule

`default_nettype wire

// ==== design/vcpu.sv ====
// thumb data-processing subset only; no pc advance, loads, stores or branches
`timescale 1ns/1ps
`default_nettype none

module vcpu (
    input  logic               sck,
    input  logic               rst_n_i,
    input  logic               cmd_valid_i,
    input  logic [15:0]        cmd_i,
    output logic               cmd_ready_o,
    output logic               res_valid_o,
    output vcpu_pkg::word_t    res_value_o,
    output vcpu_pkg::reg_idx_t res_rd_o,
    input  logic               res_ready_i,
    output vcpu_pkg::flags_t   flags_o
);
    import vcpu_pkg::*;

    exec_if    ex_bus ();
    rf_read_if rf_bus ();

    unit_res_t shift_res;
    unit_res_t add_res;
    unit_res_t logic_res;

    thumb_decoder i_decoder (
        .sck         (sck),
        .rst_n_i     (rst_n_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_i       (cmd_i),
        .cmd_ready_o (cmd_ready_o),
        .ex          (ex_bus),
        .rf          (rf_bus)
    );

    shift_unit i_shift (
        .ex    (ex_bus),
        .res_o (shift_res)
    );

    adder_unit i_adder (
        .ex    (ex_bus),
        .res_o (add_res)
    );

    logic_mul_unit i_logic_mul (
        .ex    (ex_bus),
        .res_o (logic_res)
    );

    reg_file i_reg_file (
        .sck         (sck),
        .rst_n_i     (rst_n_i),
        .ex          (ex_bus),
        .rf          (rf_bus),
        .shift_res_i (shift_res),
        .add_res_i   (add_res),
        .logic_res_i (logic_res),
        .res_valid_o (res_valid_o),
        .res_value_o (res_value_o),
        .res_rd_o    (res_rd_o),
        .res_ready_i (res_ready_i),
        .flags_o     (flags_o)
    );

endmodule

`default_nettype wire

// ==== test/tb_vcpu.sv ====
// results are checked against a register and flag model; immediate shift amounts are taken as encoded
`timescale 1ns/1ps
`default_nettype none

module tb_vcpu;
    import vcpu_pkg::*;

    logic        sck = 1'b0;
    logic        rst_n_i;
    logic        cmd_valid_i;
    logic [15:0] cmd_i;
    logic        cmd_ready_o;
    logic        res_valid_o;
    word_t       res_value_o;
    reg_idx_t    res_rd_o;
    logic        res_ready_i;
    flags_t      flags_o;

    word_t    m_regs [NREGS];
    flags_t   m_flags;
    word_t    exp_val [$];
    reg_idx_t exp_rd [$];
    flags_t   exp_fl [$];
    word_t    head_val;
    reg_idx_t head_rd;
    flags_t   head_fl;
    logic     head_ok = 1'b0;
    int       pending = 0;
    integer   seed = 32'h8028_9d0f;
    int       value_errs = 0;
    int       proto_errs = 0;
    int       issued = 0;
    int       cycles = 0;
    logic     stall_en = 1'b0;

    vcpu i_dut (
        .sck         (sck),
        .rst_n_i     (rst_n_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_i       (cmd_i),
        .cmd_ready_o (cmd_ready_o),
        .res_valid_o (res_valid_o),
        .res_value_o (res_value_o),
        .res_rd_o    (res_rd_o),
        .res_ready_i (res_ready_i),
        .flags_o     (flags_o)
    );

    always #50 sck = ~sck;

    always @(negedge sck) begin
        res_ready_i <= stall_en ? 1'($random(seed)) : 1'b1;
    end

    task automatic refresh_head();
        head_ok = exp_val.size() > 0;
        pending = exp_val.size();
        if (head_ok) begin
            head_val = exp_val[0];
            head_rd  = exp_rd[0];
            head_fl  = exp_fl[0];
        end
    endtask

    task automatic add_calc(input word_t n, input word_t m, input logic cin,
                            output word_t v, output logic cy, output logic ov);
        {cy, v} = {1'b0, n} + {1'b0, m} + 33'(cin);
        ov = (n[31] == m[31]) && (v[31] != n[31]);
    endtask

    // kind 0 lsl, 1 lsr, 2 asr, 3 ror; amount is the full unsaturated count
    task automatic shift_calc(input int kind, input word_t n, input int amt,
                              output word_t v, inout logic cy);
        v = n;
        if (amt != 0) begin
            case (kind)
                0: begin
                    v  = (amt < 32) ? n << amt : '0;
                    cy = (amt <= 32) ? n[32-amt] : 1'b0;
                end
                1: begin
                    v  = (amt < 32) ? n >> amt : '0;
                    cy = (amt <= 32) ? n[amt-1] : 1'b0;
                end
                2: begin
                    v  = (amt < 32) ? word_t'($signed(n) >>> amt) : {32{n[31]}};
                    cy = (amt <= 32) ? n[amt-1] : n[31];
                end
                default: begin
                    v  = (n >> (amt % 32)) | (n << (32 - amt % 32));
                    cy = v[31];
                end
            endcase
        end
    endtask

    task automatic run_model(input logic [15:0] c);
        word_t    n;
        word_t    m;
        word_t    v;
        logic     cy;
        logic     ov;
        logic     ok;
        logic     we;
        logic     sf;
        logic     is_add;
        reg_idx_t rd;
        ok = 1'b1;
        we = 1'b1;
        sf = 1'b1;
        is_add = 1'b0;
        cy = m_flags.c;
        ov = 1'b0;
        v = '0;
        rd = {1'b0, c[2:0]};
        if (c[15:11] == 5'b00011) begin
            n = m_regs[c[5:3]];
            m = c[10] ? word_t'(c[8:6]) : m_regs[c[8:6]];
            add_calc(n, c[9] ? ~m : m, c[9], v, cy, ov);
            is_add = 1'b1;
        end else if (c[15:13] == 3'b000) begin
            shift_calc(int'(c[12:11]), m_regs[c[5:3]], int'(c[10:6]), v, cy);
        end else if (c[15:13] == 3'b001) begin
            rd = {1'b0, c[10:8]};
            n = m_regs[rd];
            m = word_t'(c[7:0]);
            is_add = 1'b1;
            case (c[12:11])
                2'b00: add_calc('0, m, 1'b0, v, cy, ov);
                2'b01: begin
                    add_calc(n, ~m, 1'b1, v, cy, ov);
                    we = 1'b0;
                end
                2'b10: add_calc(n, m, 1'b0, v, cy, ov);
                default: add_calc(n, ~m, 1'b1, v, cy, ov);
            endcase
        end else if (c[15:10] == 6'b010000) begin
            n = m_regs[c[2:0]];
            m = m_regs[c[5:3]];
            is_add = c[9:6] inside {4'd5, 4'd6, 4'd9, 4'd10, 4'd11, 4'd15};
            we = !(c[9:6] inside {4'd8, 4'd10, 4'd11});
            case (c[9:6])
                4'd0:  v = n & m;
                4'd1:  v = n ^ m;
                4'd2:  shift_calc(0, n, int'(m[7:0]), v, cy);
                4'd3:  shift_calc(1, n, int'(m[7:0]), v, cy);
                4'd4:  shift_calc(2, n, int'(m[7:0]), v, cy);
                4'd5:  add_calc(n, m, m_flags.c, v, cy, ov);
                4'd6:  add_calc(n, ~m, m_flags.c, v, cy, ov);
                4'd7:  shift_calc(3, n, int'(m[7:0]), v, cy);
                4'd8:  v = n & m;
                4'd9:  add_calc('0, ~m, 1'b1, v, cy, ov);
                4'd10: add_calc(n, ~m, 1'b1, v, cy, ov);
                4'd11: add_calc(n, m, 1'b0, v, cy, ov);
                4'd12: v = n | m;
                4'd13: v = n * m;
                4'd14: v = n & ~m;
                default: add_calc('0, ~m, 1'b0, v, cy, ov);
            endcase
        end else if (c[15:10] == 6'b010001 && c[9:8] != 2'b11) begin
            rd = {c[7], c[2:0]};
            n = m_regs[rd];
            m = m_regs[c[6:3]];
            sf = rd != REG_PC;
            we = c[9:8] != 2'b01;
            is_add = 1'b1;
            case (c[9:8])
                2'b00: add_calc(n, m, 1'b0, v, cy, ov);
                2'b01: add_calc(n, ~m, 1'b1, v, cy, ov);
                default: add_calc('0, m, 1'b0, v, cy, ov);
            endcase
        end else begin
            ok = 1'b0;
        end
        if (ok) begin
            if (we) begin
                m_regs[rd] = v;
            end
            if (sf) begin
                m_flags.n = v[31];
                m_flags.z = v == '0;
                m_flags.c = cy;
                if (is_add) begin
                    m_flags.v = ov;
                end
            end
            exp_val.push_back(v);
            exp_rd.push_back(rd);
            exp_fl.push_back(m_flags);
            refresh_head();
        end
    endtask

    task automatic issue(input logic [15:0] c);
        @(negedge sck);
        cmd_valid_i = 1'b1;
        cmd_i = c;
        #1;
        while (!cmd_ready_o) begin
            @(negedge sck);
            #1;
        end
        @(posedge sck);
        run_model(c);
        issued++;
    endtask

    // mov, then shift in the remaining bytes
    task automatic load_reg(input int r, input word_t w);
        issue(16'h2000 | 16'(r << 8) | 16'(w[31:24]));
        for (int b = 2; b >= 0; b--) begin
            issue(16'h0200 | 16'(r << 3) | 16'(r));
            issue(16'h3000 | 16'(r << 8) | 16'(w[8*b +: 8]));
        end
    endtask

    always @(posedge sck) begin
        if (rst_n_i && res_valid_o && res_ready_i && exp_val.size() > 0) begin
            void'(exp_val.pop_front());
            void'(exp_rd.pop_front());
            void'(exp_fl.pop_front());
            refresh_head();
        end
    end

    a_reset_state: assert property (@(posedge sck) $rose(rst_n_i) |->
        !res_valid_o && flags_o == '0 && cmd_ready_o)
        else begin
            value_errs++;
            $display("[ERROR] %0t: outputs not idle after reset", $time);
        end

    a_result_expected: assert property (@(posedge sck) disable iff (!rst_n_i)
        res_valid_o && res_ready_i |-> head_ok)
        else begin
            proto_errs++;
            $display("result transfer at %0t with no command waiting for one", $time);
        end

    a_result_value: assert property (@(posedge sck) disable iff (!rst_n_i)
        res_valid_o && res_ready_i && head_ok |->
        res_value_o == head_val && res_rd_o == head_rd && flags_o == head_fl)
        else begin
            value_errs++;
            $display("[ERROR] %0t: r%0d value %h flags %b, expected r%0d %h flags %b", $time,
                     $sampled(res_rd_o), $sampled(res_value_o), $sampled(flags_o),
                     $sampled(head_rd), $sampled(head_val), $sampled(head_fl));
        end

    a_result_hold: assert property (@(posedge sck) disable iff (!rst_n_i)
        res_valid_o && !res_ready_i |=>
        res_valid_o && $stable(res_value_o) && $stable(res_rd_o))
        else begin
            value_errs++;
            $display("[ERROR] %0t: stalled result changed or dropped", $time);
        end

    // a held result with a second command behind it blocks new commands
    a_cmd_backpressure: assert property (@(posedge sck) disable iff (!rst_n_i)
        cmd_ready_o == !(res_valid_o && !res_ready_i && pending > 1))
        else begin
            proto_errs++;
            $display("command ready did not follow result back-pressure at %0t", $time);
        end

    always @(posedge sck) begin
        cycles++;
        if (cycles > 4 * issued + 200) begin
            $display("timeout: run stopped after %0d cycles with %0d commands", cycles, issued);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        int amts [8] = '{0, 5, 31, 32, 33, 40, 64, 255};
        rst_n_i = 1'b0;
        cmd_valid_i = 1'b0;
        cmd_i = '0;
        res_ready_i = 1'b1;
        for (int r = 0; r < NREGS; r++) begin
            m_regs[r] = '0;
        end
        m_flags = '0;
        repeat (8) @(negedge sck);
        rst_n_i = 1'b1;
        // immediates and three-register add/sub
        for (int r = 0; r < 8; r++) begin
            issue(16'h2000 | 16'(r << 8) | 16'($random(seed) & 8'hff));
        end
        issue(16'h3000 | 16'h0200 | 16'h00f0);
        issue(16'h3800 | 16'h0300 | 16'h00ff);
        issue(16'h2800 | 16'h0100 | 16'h0080);
        issue(16'h2800 | 16'h0400 | 16'h0000);
        issue(16'h1800 | 16'(3 << 6) | 16'(2 << 3) | 16'd5);
        issue(16'h1A00 | 16'(6 << 6) | 16'(1 << 3) | 16'd7);
        issue(16'h1C00 | 16'(7 << 6) | 16'(4 << 3) | 16'd4);
        issue(16'h1E00 | 16'(5 << 6) | 16'(0 << 3) | 16'd0);
        // immediate then register shifts over edge amounts
        load_reg(2, 32'h8765_4321);
        issue(16'h0000 | 16'(0 << 6) | 16'(2 << 3) | 16'd3);
        issue(16'h0800 | 16'(1 << 6) | 16'(2 << 3) | 16'd3);
        issue(16'h1000 | 16'(31 << 6) | 16'(2 << 3) | 16'd3);
        for (int a = 0; a < 8; a++) begin
            issue(16'h2100 | 16'(amts[a]));
            for (int op = 2; op <= 7; op++) begin
                if (op == 2 || op == 3 || op == 4 || op == 7) begin
                    issue(16'h0000 | 16'(2 << 3) | 16'd3);
                    issue(16'h4000 | 16'(op << 6) | 16'(1 << 3) | 16'd3);
                end
            end
        end
        // carry chains back to back
        issue(16'h2800 | 16'h0000);
        issue(16'h4000 | 16'(5 << 6) | 16'(3 << 3) | 16'd2);
        issue(16'h4000 | 16'(6 << 6) | 16'(5 << 3) | 16'd4);
        issue(16'h4000 | 16'(5 << 6) | 16'(2 << 3) | 16'd4);
        // random data-processing, then with back-pressure
        for (int i = 0; i < 120; i++) begin
            if (i == 60) begin
                stall_en = 1'b1;
            end
            if (i % 8 == 0) begin
                load_reg($random(seed) & 7, $random(seed));
            end
            issue(16'h4000 | 16'(($random(seed) & 15) << 6) | 16'(($random(seed) & 7) << 3)
                  | 16'($random(seed) & 7));
        end
        stall_en = 1'b0;
        // high registers, r15 flag rule and unsupported opcodes
        for (int r = 8; r < NREGS; r++) begin
            issue(16'h4600 | 16'(((r >> 3) & 1) << 7) | 16'((r & 7) << 3) | 16'(r & 7));
            issue(16'h4400 | 16'h0080 | 16'((r - 8) << 3) | 16'(r & 7));
        end
        issue(16'h4500 | 16'h0080 | 16'(1 << 3) | 16'd7);
        issue(16'h4400 | 16'(15 << 3) | 16'd2);
        issue(16'hB000);
        issue(16'hD0FE);
        issue(16'h4700);
        issue(16'h6808);
        issue(16'hDF00);
        for (int r = 8; r < NREGS; r++) begin
            issue(16'h4600 | 16'(r << 3) | 16'd0);
        end
        issue(16'h2800 | 16'h0300);
        @(negedge sck);
        cmd_valid_i = 1'b0;
        while (exp_val.size() != 0) begin
            @(posedge sck);
        end
        repeat (4) @(posedge sck);
        $display("%0d commands, %0d value errors, %0d protocol errors",
                 issued, value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
common/vcpu_pkg.sv
common/exec_if.sv
common/rf_read_if.sv
decode/thumb_decoder.sv
execute/shift_unit.sv
execute/adder_unit.sv
execute/logic_mul_unit.sv
design/reg_file.sv
design/vcpu.sv
test/tb_vcpu.sv

// ==== Bender.yml ====
package:
  name: vcpu

sources:
  - common/vcpu_pkg.sv
  - common/exec_if.sv
  - common/rf_read_if.sv
  - decode/thumb_decoder.sv
  - execute/shift_unit.sv
  - execute/adder_unit.sv
  - execute/logic_mul_unit.sv
  - design/reg_file.sv
  - design/vcpu.sv
  - target: test
    files:
      - test/tb_vcpu.sv
